// ==== organ_settings.svh ====
`ifndef ORGAN_SETTINGS_SVH
`define ORGAN_SETTINGS_SVH

// ============================================================
// Bus and display widths
// ============================================================
`define ORGAN_DATA_W 32
`define ORGAN_DIGITS 6

// Register byte addresses
`define ORGAN_ADDR_CTRL  4'h0
`define ORGAN_ADDR_SPEED 4'h4
`define ORGAN_ADDR_NAME  4'h8
`define ORGAN_ADDR_COUNT 4'hC

// ============================================================
// Note half-periods in 50 MHz cycles
// ============================================================
`define ORGAN_HALF_DO  16'd47801
`define ORGAN_HALF_RE  16'd42589
`define ORGAN_HALF_MI  16'd37936
`define ORGAN_HALF_FA  16'd35816
`define ORGAN_HALF_SO  16'd31888
`define ORGAN_HALF_LA  16'd28409
`define ORGAN_HALF_SI  16'd25310
`define ORGAN_HALF_DO2 16'd23900

// Scope sampling count, 2 kHz at rest
`define ORGAN_SPEED_STEP    16'd100
`define ORGAN_DEFAULT_COUNT 16'd12499

`endif

// ==== organ_pkg.sv ====
`include "organ_settings.svh"

package organ_pkg;

  // Eight notes of the scale, Do up to the octave
  typedef enum logic [2:0] {
    do_n,
    re_n,
    mi_n,
    fa_n,
    so_n,
    la_n,
    si_n,
    do2_n
  } note_e;

  // ============================================================
  // APB write word, two views selected by address
  // ============================================================
  typedef struct packed {
    logic [`ORGAN_DATA_W-5:0] reserved;
    note_e                    note;
    logic                     tone_enable;
  } ctrl_word_t;

  typedef struct packed {
    logic [`ORGAN_DATA_W-4:0] reserved;
    logic                     reset;
    logic                     down;
    logic                     up;
  } speed_cmd_t;

  typedef union packed {
    ctrl_word_t ctrl;
    speed_cmd_t speed;
  } organ_wdata_u;

  // APB request and response
  typedef struct packed {
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [3:0]   paddr;
    organ_wdata_u pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`ORGAN_DATA_W-1:0] prdata;
    logic                     pslverr;
  } apb_rsp_t;

  // Stage-to-stage payloads
  typedef struct packed {
    logic  tone_enable;
    note_e note;
  } tone_ctrl_t;

  typedef struct packed {
    logic reset;
    logic down;
    logic up;
  } speed_cmd_pulse_t;

  // Segments g..a, active low
  typedef logic [6:0] seg7_t;

  typedef logic signed [7:0] audio_sample_t;

endpackage

// ==== organ_apb_regs.sv ====
`include "organ_settings.svh"

module organ_apb_regs
(
  input  logic                        CLK_50M,
  input  logic                        arst_n,
  input  organ_pkg::apb_req_t         apb_req,
  input  logic [15:0]                 sample_count,
  output organ_pkg::apb_rsp_t         apb_rsp,
  output organ_pkg::tone_ctrl_t       tone_ctrl,
  output organ_pkg::speed_cmd_pulse_t speed_cmd
);

  logic                     access;
  logic                     addr_ok;
  logic                     write_ok;
  logic                     bad_access;
  logic                     wr_en;
  logic [`ORGAN_DATA_W-1:0] rdata;

  // ASCII name, right-aligned, two or three characters
  function automatic logic [23:0] note_name(input organ_pkg::note_e note);
    case (note)
      organ_pkg::do_n: note_name = {8'h00, "Do"};
      organ_pkg::re_n: note_name = {8'h00, "Re"};
      organ_pkg::mi_n: note_name = {8'h00, "Mi"};
      organ_pkg::fa_n: note_name = {8'h00, "Fa"};
      organ_pkg::so_n: note_name = {8'h00, "So"};
      organ_pkg::la_n: note_name = {8'h00, "La"};
      organ_pkg::si_n: note_name = {8'h00, "Si"};
      default:         note_name = "DO2";
    endcase
  endfunction

  // ============================================================
  // Address decode and read mux
  // ============================================================
  always_comb
  begin
    addr_ok  = 1'b1;
    write_ok = 1'b0;
    rdata    = '0;
    case (apb_req.paddr)
      `ORGAN_ADDR_CTRL:
      begin
        write_ok = 1'b1;
        rdata    = {{(`ORGAN_DATA_W-4){1'b0}}, tone_ctrl.note, tone_ctrl.tone_enable};
      end
      // Write-only, reads as zero
      `ORGAN_ADDR_SPEED: write_ok = 1'b1;
      `ORGAN_ADDR_NAME:  rdata = {{(`ORGAN_DATA_W-24){1'b0}}, note_name(tone_ctrl.note)};
      `ORGAN_ADDR_COUNT: rdata = {{(`ORGAN_DATA_W-16){1'b0}}, sample_count};
      default:           addr_ok = 1'b0;
    endcase
  end

  assign access     = apb_req.psel & apb_req.penable;
  assign bad_access = access & (~addr_ok | (apb_req.pwrite & ~write_ok));
  assign wr_en      = access & apb_req.pwrite & ~bad_access;

  // Zero wait states, response lives in the access phase
  assign apb_rsp.pslverr = bad_access;
  assign apb_rsp.prdata  = (access & ~apb_req.pwrite & ~bad_access) ? rdata : '0;

  // ============================================================
  // Control register and command pulses
  // ============================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tone_ctrl <= '0;
      speed_cmd <= '0;
    end
    else
    begin
      speed_cmd <= '0;
      if (wr_en && apb_req.paddr == `ORGAN_ADDR_CTRL)
      begin
        tone_ctrl.tone_enable <= apb_req.pwdata.ctrl.tone_enable;
        tone_ctrl.note        <= apb_req.pwdata.ctrl.note;
      end
      // One-cycle pulse per SPEED write
      if (wr_en && apb_req.paddr == `ORGAN_ADDR_SPEED)
      begin
        speed_cmd.up    <= apb_req.pwdata.speed.up;
        speed_cmd.down  <= apb_req.pwdata.speed.down;
        speed_cmd.reset <= apb_req.pwdata.speed.reset;
      end
    end
  end

endmodule

// ==== tone_synth.sv ====
`include "organ_settings.svh"

module tone_synth
#(
  parameter int CLK_DIV_SHIFT = 0
)
(
  input  logic                     CLK_50M,
  input  logic                     arst_n,
  input  organ_pkg::tone_ctrl_t    tone_ctrl,
  output organ_pkg::audio_sample_t audio_sample
);

  organ_pkg::tone_ctrl_t ctrl_q;
  logic                  ctrl_changed;
  logic [15:0]           half_limit;
  logic [15:0]           counter;
  logic                  wave;

  // Half-period of each note at 50 MHz
  function automatic logic [15:0] half_period(input organ_pkg::note_e note);
    case (note)
      organ_pkg::do_n: half_period = `ORGAN_HALF_DO;
      organ_pkg::re_n: half_period = `ORGAN_HALF_RE;
      organ_pkg::mi_n: half_period = `ORGAN_HALF_MI;
      organ_pkg::fa_n: half_period = `ORGAN_HALF_FA;
      organ_pkg::so_n: half_period = `ORGAN_HALF_SO;
      organ_pkg::la_n: half_period = `ORGAN_HALF_LA;
      organ_pkg::si_n: half_period = `ORGAN_HALF_SI;
      default:         half_period = `ORGAN_HALF_DO2;
    endcase
  endfunction

  assign half_limit   = (half_period(tone_ctrl.note) >> CLK_DIV_SHIFT) - 16'd1;
  assign ctrl_changed = (tone_ctrl != ctrl_q);

  // ============================================================
  // Divider and square wave
  // ============================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl_q       <= '0;
      counter      <= '0;
      wave         <= 1'b0;
      audio_sample <= '0;
    end
    else
    begin
      ctrl_q <= tone_ctrl;
      // New note or enable restarts the count
      if (ctrl_changed)
        counter <= '0;
      else if (counter == half_limit)
      begin
        counter <= '0;
        wave    <= ~wave;
      end
      else
        counter <= counter + 16'd1;

      // Full-scale signed sample from the wave
      if (!tone_ctrl.tone_enable)
        audio_sample <= '0;
      else if (wave)
        audio_sample <= 8'sh7F;
      else
        audio_sample <= 8'sh80;
    end
  end

endmodule

// ==== scope_rate_ctrl.sv ====
`include "organ_settings.svh"

module scope_rate_ctrl
(
  input  logic                        CLK_50M,
  input  logic                        arst_n,
  input  organ_pkg::speed_cmd_pulse_t speed_cmd,
  output logic [15:0]                 sample_count
);

  // Signed offset from the default count
  logic signed [15:0] speed;

  // ============================================================
  // Speed accumulator
  // ============================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      speed <= '0;
    else if (speed_cmd.reset)
      speed <= '0;
    else if (speed_cmd.up)
      speed <= speed + $signed(`ORGAN_SPEED_STEP);
    else if (speed_cmd.down)
      speed <= speed - $signed(`ORGAN_SPEED_STEP);
  end

  // Count register, wraps at 16 bits
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      sample_count <= `ORGAN_DEFAULT_COUNT;
    else
      sample_count <= `ORGAN_DEFAULT_COUNT + $unsigned(speed);
  end

endmodule

// ==== hex_display.sv ====
`include "organ_settings.svh"

module hex_display
(
  input  logic                                   CLK_50M,
  input  logic                                   arst_n,
  input  logic [15:0]                            sample_count,
  output organ_pkg::seg7_t [`ORGAN_DIGITS-1:0]   hex
);

  localparam int VALUE_W = 4 * `ORGAN_DIGITS;
  localparam logic [VALUE_W-1:0] RESET_VALUE = {{(VALUE_W-16){1'b0}}, `ORGAN_DEFAULT_COUNT};

  logic [VALUE_W-1:0] value;

  // Active-low hex patterns for segments g..a
  function automatic organ_pkg::seg7_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  assign value = {{(VALUE_W-16){1'b0}}, sample_count};

  // Reset shows the default count
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `ORGAN_DIGITS; i++)
        hex[i] <= seg_decode(RESET_VALUE[4*i +: 4]);
    end
    else
    begin
      for (int i = 0; i < `ORGAN_DIGITS; i++)
        hex[i] <= seg_decode(value[4*i +: 4]);
    end
  end

endmodule

// ==== organ_top.sv ====
`include "organ_settings.svh"

module organ_top
#(
  parameter int CLK_DIV_SHIFT = 0
)
(
  input  logic                                 CLK_50M,
  input  logic                                 arst_n,
  input  organ_pkg::apb_req_t                  apb_req,
  output organ_pkg::apb_rsp_t                  apb_rsp,
  output organ_pkg::audio_sample_t             audio_sample,
  output organ_pkg::seg7_t [`ORGAN_DIGITS-1:0] hex
);

  organ_pkg::tone_ctrl_t       tone_ctrl;
  organ_pkg::speed_cmd_pulse_t speed_cmd;
  logic [15:0]                 sample_count;

  // ============================================================
  // Register stage
  // ============================================================
  organ_apb_regs u_regs
  (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .apb_req      (apb_req),
    .sample_count (sample_count),
    .apb_rsp      (apb_rsp),
    .tone_ctrl    (tone_ctrl),
    .speed_cmd    (speed_cmd)
  );

  // Tone path
  tone_synth
  #(
    .CLK_DIV_SHIFT (CLK_DIV_SHIFT)
  )
  u_tone
  (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .tone_ctrl    (tone_ctrl),
    .audio_sample (audio_sample)
  );

  // ============================================================
  // Scope rate and display
  // ============================================================
  scope_rate_ctrl u_rate
  (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .speed_cmd    (speed_cmd),
    .sample_count (sample_count)
  );

  hex_display u_hex
  (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sample_count (sample_count),
    .hex          (hex)
  );

endmodule

// ==== organ_sva.sv ====
`include "organ_settings.svh"

module organ_sva
(
  input logic                     CLK_50M,
  input logic                     arst_n,
  input organ_pkg::apb_req_t      apb_req,
  input organ_pkg::apb_rsp_t      apb_rsp,
  input organ_pkg::audio_sample_t audio_sample
);

  timeunit 1ns;
  timeprecision 1ps;

  // ============================================================
  // Bus response
  // ============================================================
  a_slverr_in_access: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
    else $error("pslverr high outside an access phase");

  // Only silence or full scale
  a_sample_levels: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (audio_sample == 8'sh00) || (audio_sample == 8'sh7F) || (audio_sample == 8'sh80))
    else $error("audio_sample has an illegal level");

  // Disable reaches the sample two edges after the write
  a_disable_silences: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (apb_req.psel && apb_req.penable && apb_req.pwrite &&
     apb_req.paddr == `ORGAN_ADDR_CTRL && !apb_req.pwdata.ctrl.tone_enable)
    |-> ##2 (audio_sample == 8'sh00))
    else $error("audio_sample not silent after tone disable");

endmodule

bind organ_top organ_sva u_sva
(
  .CLK_50M      (CLK_50M),
  .arst_n       (arst_n),
  .apb_req      (apb_req),
  .apb_rsp      (apb_rsp),
  .audio_sample (audio_sample)
);

// ==== organ_tb.sv ====
`include "organ_settings.svh"

module organ_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_DIV_SHIFT = 6;
  localparam int MAX_HALF      = int'(`ORGAN_HALF_DO) >> CLK_DIV_SHIFT;
  localparam int MARGIN        = 4000;

  typedef organ_pkg::seg7_t [`ORGAN_DIGITS-1:0] digits_t;

  logic                     CLK_50M;
  logic                     arst_n;
  organ_pkg::apb_req_t      apb_req;
  organ_pkg::apb_rsp_t      apb_rsp;
  organ_pkg::audio_sample_t audio_sample;
  digits_t                  hex;

  // Test table from the data file
  string       test_name [$];
  string       test_op   [$];
  logic [3:0]  test_addr [$];
  logic [31:0] test_data [$];
  logic [31:0] test_exp  [$];

  string       cur_name;
  bit          test_ok;
  int          n_tests;
  int          n_pass;
  int          n_fail;
  int          seed;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] rd_data;
  logic        rd_err;

  organ_top
  #(
    .CLK_DIV_SHIFT (CLK_DIV_SHIFT)
  )
  dut
  (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .audio_sample (audio_sample),
    .hex          (hex)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ============================================================
  // Expected values
  // ============================================================
  // Lit segments of each digit shape, driven low to light
  function automatic organ_pkg::seg7_t seg_pattern(input logic [3:0] nibble);
    string            lit;
    string            names;
    organ_pkg::seg7_t seg;
    names = "abcdefg";
    case (nibble)
      4'h0: lit = "abcdef";
      4'h1: lit = "bc";
      4'h2: lit = "abdeg";
      4'h3: lit = "abcdg";
      4'h4: lit = "bcfg";
      4'h5: lit = "acdfg";
      4'h6: lit = "acdefg";
      4'h7: lit = "abc";
      4'h8: lit = "abcdefg";
      4'h9: lit = "abcdfg";
      4'hA: lit = "abcefg";
      4'hB: lit = "cdefg";
      4'hC: lit = "adef";
      4'hD: lit = "bcdeg";
      4'hE: lit = "adefg";
      default: lit = "aefg";
    endcase
    seg = 7'h7F;
    for (int s = 0; s < 7; s++)
      for (int i = 0; i < lit.len(); i++)
        if (lit.getc(i) == names.getc(s))
          seg[s] = 1'b0;
    seg_pattern = seg;
  endfunction

  // Count zero-extended to six digits
  function automatic digits_t expected_hex(input logic [15:0] count);
    logic [23:0] value;
    value = {8'h00, count};
    for (int i = 0; i < `ORGAN_DIGITS; i++)
      expected_hex[i] = seg_pattern(value[4*i +: 4]);
  endfunction

  // ============================================================
  // Compare tasks
  // ============================================================
  task automatic check_rdata(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", cur_name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_slverr(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected pslverr %b, actual %b", cur_name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_sample(input organ_pkg::audio_sample_t exp,
                              input organ_pkg::audio_sample_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected sample 0x%02h, actual 0x%02h", cur_name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_hex(input organ_pkg::seg7_t [`ORGAN_DIGITS-1:0] exp,
                           input organ_pkg::seg7_t [`ORGAN_DIGITS-1:0] act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected segments 0x%011h, actual 0x%011h", cur_name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_period(input int exp, input int act);
    if (act != exp)
    begin
      $display("FAILED %s: expected half-period %0d, actual %0d", cur_name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  // ============================================================
  // Bus and stimulus helpers
  // ============================================================
  task automatic apb_transfer(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata);
    int idle;
    idle = {$random(seed)} % 4;
    repeat (idle) @(negedge CLK_50M);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge CLK_50M);
    apb_req.penable = 1'b1;
    // Response has settled by the middle of the low phase
    #5;
    rd_data = apb_rsp.prdata;
    rd_err  = apb_rsp.pslverr;
    @(negedge CLK_50M);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic next_change(output int cycles, output organ_pkg::audio_sample_t level);
    organ_pkg::audio_sample_t start;
    start  = audio_sample;
    cycles = 0;
    do
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    while (audio_sample === start);
    level = audio_sample;
  endtask

  task automatic run_tone(input logic [3:0] addr, input logic [31:0] data,
                          input logic [31:0] exp);
    int                       cycles;
    organ_pkg::audio_sample_t level;
    organ_pkg::audio_sample_t level2;
    apb_transfer(1'b1, addr, data);
    check_slverr(1'b0, rd_err);
    apb_transfer(1'b0, addr, 32'h0);
    check_rdata(data & 32'hF, rd_data);
    if (exp == 32'h0)
    begin
      // Silent for a whole period of the lowest note
      for (int i = 0; i < 2 * MAX_HALF + 4 && test_ok; i++)
      begin
        @(negedge CLK_50M);
        check_sample(8'sh00, audio_sample);
      end
    end
    else
    begin
      // First change may follow the restart, so measure the next one
      next_change(cycles, level);
      next_change(cycles, level);
      check_sample(level[7] ? 8'sh80 : 8'sh7F, level);
      next_change(cycles, level2);
      check_sample(level[7] ? 8'sh7F : 8'sh80, level2);
      check_period(int'(exp), cycles);
    end
  endtask

  task automatic run_speed(input logic [3:0] addr, input logic [31:0] data,
                           input logic [31:0] exp);
    apb_transfer(1'b1, addr, data);
    check_slverr(1'b0, rd_err);
    // Pulse, speed, count, then segments
    repeat (3) @(negedge CLK_50M);
    check_hex(expected_hex(exp[15:0]), hex);
    apb_transfer(1'b0, `ORGAN_ADDR_COUNT, 32'h0);
    check_rdata(exp, rd_data);
  endtask

  task automatic run_test(input int k);
    cur_name = test_name[k];
    test_ok  = 1'b1;
    if (test_op[k] == "write")
    begin
      apb_transfer(1'b1, test_addr[k], test_data[k]);
      check_slverr(test_exp[k][0], rd_err);
    end
    else if (test_op[k] == "read")
    begin
      apb_transfer(1'b0, test_addr[k], 32'h0);
      check_slverr(test_data[k][0], rd_err);
      check_rdata(test_exp[k], rd_data);
    end
    else if (test_op[k] == "tone")
      run_tone(test_addr[k], test_data[k], test_exp[k]);
    else if (test_op[k] == "speed")
      run_speed(test_addr[k], test_data[k], test_exp[k]);
    else
    begin
      $display("Test %s has an unknown operation %s", cur_name, test_op[k]);
      test_ok = 1'b0;
    end
    if (test_ok)
    begin
      n_pass++;
      $display("PASS %s", cur_name);
    end
    else
    begin
      n_fail++;
      $display("FAIL %s", cur_name);
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          cnt;
    string       line;
    string       nm;
    string       op;
    logic [3:0]  ad;
    logic [31:0] dt;
    logic [31:0] ex;
    fd = $fopen("organ_input.txt", "r");
    if (fd == 0)
      $display("Could not open organ_input.txt");
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 0 && line.getc(0) != "#")
        begin
          cnt = $sscanf(line, "%s %s %h %h %h", nm, op, ad, dt, ex);
          if (cnt == 5)
          begin
            test_name.push_back(nm);
            test_op.push_back(op);
            test_addr.push_back(ad);
            test_data.push_back(dt);
            test_exp.push_back(ex);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial
  begin
    seed    = 77905;
    n_pass  = 0;
    n_fail  = 0;
    arst_n  = 1'b0;
    apb_req = '0;
    load_tests();
    n_tests     = test_name.size();
    cycle_limit = n_tests * 2 * MAX_HALF + MARGIN;
    repeat (8) @(negedge CLK_50M);
    arst_n = 1'b1;
    if (n_tests == 0)
    begin
      $display("No tests were read from organ_input.txt");
      n_fail++;
    end
    for (int k = 0; k < n_tests; k++)
      run_test(k);
    $display("Tests: %0d run, %0d passed, %0d failed", n_tests, n_pass, n_fail);
    if (n_fail == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Watchdog on the whole run
  initial
  begin
    cycle_cnt = 0;
    @(posedge arst_n);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge CLK_50M);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== organ_input.txt ====
# columns: name op addr data expected, all numbers hex
# write: expected is pslverr; read: data is pslverr; tone: data goes to CTRL; speed: expected is COUNT
reset_count     read  c 0 30d3
reset_ctrl      read  0 0 0
reset_display   speed 4 0 30d3
reset_silent    tone  0 0 0
do_tone         tone  0 1 2ea
do_name         read  8 0 446f
re_tone         tone  0 3 299
re_name         read  8 0 5265
mi_tone         tone  0 5 250
mi_name         read  8 0 4d69
fa_tone         tone  0 7 22f
fa_name         read  8 0 4661
so_tone         tone  0 9 1f2
so_name         read  8 0 536f
la_tone         tone  0 b 1bb
la_name         read  8 0 4c61
si_tone         tone  0 d 18b
si_name         read  8 0 5369
do2_tone        tone  0 f 175
do2_name        read  8 0 444f32
off_tone        tone  0 e 0
spd_up          speed 4 1 3137
spd_up_again    speed 4 1 319b
spd_down        speed 4 2 3137
spd_reset       speed 4 4 30d3
spd_down_only   speed 4 2 306f
spd_all_bits    speed 4 7 30d3
spd_up_down     speed 4 3 3137
bad_name_wr     write 8 5 1
bad_count_wr    write c 5 1
bad_addr_rd     read  2 1 0
bad_addr_wr     write 6 1 1
keep_ctrl       read  0 0 e
keep_count      read  c 0 3137
keep_tone       tone  0 e 0

// ==== list.f ====
+incdir+.
organ_pkg.sv
organ_apb_regs.sv
tone_synth.sv
scope_rate_ctrl.sv
hex_display.sv
organ_top.sv
organ_sva.sv
organ_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the organ testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module organ_tb -f list.f -o organ_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/organ_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  echo "Testbench reported a failure"
  exit 1
fi
exit 0
